// ==== source/core_pkg.sv ====
package core_pkg;

    typedef logic [31:0] word_t;     // data word or byte address
    typedef logic [4:0]  reg_idx_t;  // register index

    // instruction layout
    //   [31:26] opcode  [25:21] rd  [20:16] rs1  [15:11] rs2
    //   [15:0]  imm, sign extended for addi/lw/sw, upper half for lui
    //   sw stores rs2 at rs1 + imm
    // unlisted opcodes act as a no-op that retires without a write
    typedef enum logic [5:0] {
        op_add  = 6'h00,
        op_sub  = 6'h01,
        op_and  = 6'h02,
        op_or   = 6'h03,
        op_xor  = 6'h04,
        op_slt  = 6'h05,
        op_sltu = 6'h06,
        op_sll  = 6'h07,
        op_srl  = 6'h08,
        op_sra  = 6'h09,
        op_addi = 6'h10,
        op_lui  = 6'h11,
        op_lw   = 6'h20,
        op_sw   = 6'h21,
        op_halt = 6'h3f
    } opcode_e;

    typedef enum logic [1:0] {
        f_idle,      // ready to issue next fetch
        f_wait_rsp,  // read in flight
        f_hold       // instruction buffered for decode
    } fetch_state_e;

    typedef enum logic {
        m_idle,
        m_wait_load  // load issued, data not back yet
    } mem_state_e;

endpackage

// ==== source/alu.sv ====
module alu import core_pkg::*; (
    input  opcode_e op,
    input  word_t   src1,
    input  word_t   src2,
    input  word_t   imm,
    output word_t   result
);

    logic [4:0] shamt;

    assign shamt = src2[4:0];  // low bits only

    always_comb begin
        case (op)
            op_add:  result = src1 + src2;
            op_sub:  result = src1 - src2;
            op_and:  result = src1 & src2;
            op_or:   result = src1 | src2;
            op_xor:  result = src1 ^ src2;
            op_slt: begin
                result = {31'd0, $signed(src1) < $signed(src2)};
            end
            op_sltu: begin
                result = {31'd0, src1 < src2};
            end
            op_sll:  result = src1 << shamt;
            op_srl:  result = src1 >> shamt;
            op_sra:  result = word_t'($signed(src1) >>> shamt);
            // addi and the effective address of lw/sw share the adder
            op_addi, op_lw, op_sw: begin
                result = src1 + imm;
            end
            op_lui:  result = imm;  // already shifted by decode
            default: result = '0;
        endcase
    end

endmodule

// ==== source/reg_file.sv ====
module reg_file import core_pkg::*; (
    input  logic     clk,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2,
    input  logic     wen,
    input  reg_idx_t waddr,
    input  word_t    wdata
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // no write-through, decode stalls until writeback has landed
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// ==== source/fetch_stage.sv ====
module fetch_stage import core_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst_n,
    output logic  if_req_valid,
    input  logic  if_req_ready,
    output word_t if_req_addr,
    input  logic  if_rsp_valid,
    input  word_t if_rsp_data,
    output logic  ins_valid,
    input  logic  ins_ready,
    output word_t ins_word,
    output word_t ins_pc
);

    fetch_state_e state;
    word_t        pc;
    word_t        buf_word;  // one-entry instruction buffer
    logic         stopped;   // halt handed over

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= f_idle;
            pc      <= RESET_PC;
            stopped <= 1'b0;
        end else begin
            case (state)
                f_idle: begin
                    if (if_req_valid && if_req_ready) state <= f_wait_rsp;
                end
                f_wait_rsp: begin
                    if (if_rsp_valid) state <= f_hold;
                end
                f_hold: begin
                    if (ins_ready) begin
                        state <= f_idle;
                        pc    <= pc + 32'd4;
                        if (buf_word[31:26] == op_halt) stopped <= 1'b1;
                    end
                end
                default: state <= f_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == f_wait_rsp && if_rsp_valid) begin
            buf_word <= if_rsp_data;
        end
    end

    assign if_req_valid = (state == f_idle) && !stopped;
    assign if_req_addr  = pc;
    assign ins_valid    = (state == f_hold);
    assign ins_word     = buf_word;
    assign ins_pc       = pc;  // pc advances only after handover

endmodule

// ==== source/decode_stage.sv ====
module decode_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ins_valid,
    output logic     ins_ready,
    input  word_t    ins_word,
    input  word_t    ins_pc,
    output reg_idx_t rf_raddr1,
    output reg_idx_t rf_raddr2,
    input  word_t    rf_rdata1,
    input  word_t    rf_rdata2,
    input  logic     wb_en,
    input  reg_idx_t wb_rd,
    output logic     id_valid,
    input  logic     id_ready,
    output opcode_e  id_op,
    output reg_idx_t id_rd,
    output logic     id_wen,
    output word_t    id_src1,
    output word_t    id_src2,
    output word_t    id_imm,
    output word_t    id_pc
);

    opcode_e     op;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic        is_reg_op;
    logic        uses_rs1;
    logic        uses_rs2;
    logic        writes_rd;
    logic        hazard;
    logic        fire;
    logic [31:0] pending;  // one bit per register with a write in flight

    assign op  = opcode_e'(ins_word[31:26]);
    assign rd  = ins_word[25:21];
    assign rs1 = ins_word[20:16];
    assign rs2 = ins_word[15:11];

    always_comb begin
        is_reg_op = op inside {op_add, op_sub, op_and, op_or, op_xor,
                               op_slt, op_sltu, op_sll, op_srl, op_sra};
        uses_rs1  = is_reg_op || op inside {op_addi, op_lw, op_sw};
        uses_rs2  = is_reg_op || (op == op_sw);
        writes_rd = is_reg_op || op inside {op_addi, op_lui, op_lw};
    end

    assign hazard = (uses_rs1 && pending[rs1]) || (uses_rs2 && pending[rs2]);

    assign rf_raddr1 = rs1;
    assign rf_raddr2 = rs2;

    assign id_valid  = ins_valid && !hazard;
    assign ins_ready = id_ready && !hazard;
    assign fire      = ins_valid && ins_ready;

    assign id_op   = op;
    assign id_rd   = rd;
    assign id_wen  = writes_rd && (rd != 5'd0);
    assign id_src1 = rf_rdata1;
    assign id_src2 = rf_rdata2;
    assign id_pc   = ins_pc;
    assign id_imm  = (op == op_lui) ? {ins_word[15:0], 16'd0}
                                    : {{16{ins_word[15]}}, ins_word[15:0]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            // clear before set, a new writer of the same reg wins
            if (wb_en) pending[wb_rd] <= 1'b0;
            if (fire && id_wen) pending[rd] <= 1'b1;
        end
    end

endmodule

// ==== source/execute_stage.sv ====
module execute_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     id_valid,
    output logic     id_ready,
    input  opcode_e  id_op,
    input  reg_idx_t id_rd,
    input  logic     id_wen,
    input  word_t    id_src1,
    input  word_t    id_src2,
    input  word_t    id_imm,
    input  word_t    id_pc,
    output logic     ex_valid,
    input  logic     ex_ready,
    output opcode_e  ex_op,
    output reg_idx_t ex_rd,
    output logic     ex_wen,
    output word_t    ex_result,
    output word_t    ex_store_data,
    output word_t    ex_pc
);

    word_t alu_result;
    logic  load;

    alu u_alu (
        .op     (id_op),
        .src1   (id_src1),
        .src2   (id_src2),
        .imm    (id_imm),
        .result (alu_result)
    );

    assign load = id_valid && ex_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (ex_ready) begin
            ex_valid <= id_valid;  // refill or drain, hold otherwise
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ex_op         <= id_op;
            ex_rd         <= id_rd;
            ex_wen        <= id_wen;
            ex_result     <= alu_result;  // address for lw/sw
            ex_store_data <= id_src2;
            ex_pc         <= id_pc;
        end
    end

    assign id_ready = ex_ready;

endmodule

// ==== source/mem_stage.sv ====
module mem_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ex_valid,
    output logic     ex_ready,
    input  opcode_e  ex_op,
    input  reg_idx_t ex_rd,
    input  logic     ex_wen,
    input  word_t    ex_result,
    input  word_t    ex_store_data,
    input  word_t    ex_pc,
    output logic     dm_req_valid,
    input  logic     dm_req_ready,
    output logic     dm_req_write,
    output word_t    dm_req_addr,
    output word_t    dm_req_wdata,
    input  logic     dm_rsp_valid,
    input  word_t    dm_rsp_data,
    output logic     wb_en,
    output reg_idx_t wb_rd,
    output word_t    wb_data,
    output logic     retire_valid,
    output word_t    retire_pc,
    output logic     retire_wen,
    output reg_idx_t retire_rd,
    output word_t    retire_data,
    output logic     halted
);

    mem_state_e state;
    logic       is_mem;
    logic       fire;

    assign is_mem = (ex_op == op_lw) || (ex_op == op_sw);

    // bus request straight from the execute latch, stable until accepted
    assign dm_req_valid = ex_valid && is_mem && (state == m_idle);
    assign dm_req_write = (ex_op == op_sw);
    assign dm_req_addr  = ex_result;
    assign dm_req_wdata = ex_store_data;

    assign ex_ready = (state == m_idle) && !(ex_valid && is_mem && !dm_req_ready);
    assign fire     = ex_valid && ex_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= m_idle;
            retire_valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            retire_valid <= 1'b0;
            case (state)
                m_idle: begin
                    if (fire && ex_op == op_lw) begin
                        state <= m_wait_load;
                    end else if (fire) begin
                        retire_valid <= 1'b1;
                        if (ex_op == op_halt) halted <= 1'b1;
                    end
                end
                m_wait_load: begin
                    if (dm_rsp_valid) begin
                        state        <= m_idle;
                        retire_valid <= 1'b1;
                    end
                end
                default: state <= m_idle;
            endcase
        end
    end

    // retire payload taken at transfer, load data patched in on response
    always_ff @(posedge clk) begin
        if (fire) begin
            retire_pc   <= ex_pc;
            retire_wen  <= ex_wen;
            retire_rd   <= ex_rd;
            retire_data <= ex_result;
        end else if (state == m_wait_load && dm_rsp_valid) begin
            retire_data <= dm_rsp_data;
        end
    end

    assign wb_en   = retire_valid && retire_wen;
    assign wb_rd   = retire_rd;
    assign wb_data = retire_data;

endmodule

// ==== source/mem_arbiter.sv ====
module mem_arbiter import core_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  if_req_valid,
    output logic  if_req_ready,
    input  word_t if_req_addr,
    output logic  if_rsp_valid,
    output word_t if_rsp_data,
    input  logic  dm_req_valid,
    output logic  dm_req_ready,
    input  logic  dm_req_write,
    input  word_t dm_req_addr,
    input  word_t dm_req_wdata,
    output logic  dm_rsp_valid,
    output word_t dm_rsp_data,
    output logic  mem_req_valid,
    input  logic  mem_req_ready,
    output logic  mem_req_write,
    output word_t mem_req_addr,
    output word_t mem_req_wdata,
    input  logic  mem_rsp_valid,
    input  word_t mem_rsp_data
);

    logic       if_locked;  // fetch presented but stalled, keep bus stable
    logic       grant_dm;
    logic       push;
    logic       pop;
    logic [1:0] owner_q;    // 1 = data port, entry 0 is oldest
    logic [1:0] q_count;

    assign grant_dm = dm_req_valid && !if_locked;

    assign mem_req_valid = dm_req_valid || if_req_valid;
    assign mem_req_write = grant_dm && dm_req_write;
    assign mem_req_addr  = grant_dm ? dm_req_addr : if_req_addr;
    assign mem_req_wdata = dm_req_wdata;
    assign dm_req_ready  = grant_dm && mem_req_ready;
    assign if_req_ready  = !grant_dm && mem_req_ready;

    assign push = mem_req_valid && mem_req_ready && !mem_req_write;
    assign pop  = mem_rsp_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_locked <= 1'b0;
            q_count   <= 2'd0;
        end else begin
            if_locked <= if_req_valid && !grant_dm && !mem_req_ready;
            q_count   <= q_count + 2'(push) - 2'(pop);
        end
    end

    always_ff @(posedge clk) begin
        case ({push, pop})
            2'b10: owner_q[q_count[0]] <= grant_dm;
            2'b01: owner_q[0] <= owner_q[1];
            2'b11: begin
                if (q_count == 2'd1) begin
                    owner_q[0] <= grant_dm;
                end else begin
                    owner_q[0] <= owner_q[1];
                    owner_q[1] <= grant_dm;
                end
            end
            default: ;
        endcase
    end

    assign dm_rsp_valid = mem_rsp_valid && owner_q[0];
    assign if_rsp_valid = mem_rsp_valid && !owner_q[0];
    assign dm_rsp_data  = mem_rsp_data;
    assign if_rsp_data  = mem_rsp_data;

endmodule

// ==== source/core_top.sv ====
module core_top import core_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    output logic     mem_req_valid,
    input  logic     mem_req_ready,
    output logic     mem_req_write,
    output word_t    mem_req_addr,
    output word_t    mem_req_wdata,
    input  logic     mem_rsp_valid,
    input  word_t    mem_rsp_data,
    output logic     retire_valid,
    output word_t    retire_pc,
    output logic     retire_wen,
    output reg_idx_t retire_rd,
    output word_t    retire_data,
    output logic     halted
);

    logic     if_req_valid, if_req_ready, if_rsp_valid;
    word_t    if_req_addr, if_rsp_data;
    logic     dm_req_valid, dm_req_ready, dm_req_write, dm_rsp_valid;
    word_t    dm_req_addr, dm_req_wdata, dm_rsp_data;
    logic     ins_valid, ins_ready;
    word_t    ins_word, ins_pc;
    reg_idx_t rf_raddr1, rf_raddr2;
    word_t    rf_rdata1, rf_rdata2;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     id_valid, id_ready, id_wen;
    opcode_e  id_op;
    reg_idx_t id_rd;
    word_t    id_src1, id_src2, id_imm, id_pc;
    logic     ex_valid, ex_ready, ex_wen;
    opcode_e  ex_op;
    reg_idx_t ex_rd;
    word_t    ex_result, ex_store_data, ex_pc;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk, .rst_n,
        .if_req_valid, .if_req_ready, .if_req_addr, .if_rsp_valid, .if_rsp_data,
        .ins_valid, .ins_ready, .ins_word, .ins_pc
    );

    decode_stage u_decode (
        .clk, .rst_n,
        .ins_valid, .ins_ready, .ins_word, .ins_pc,
        .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
        .wb_en, .wb_rd,
        .id_valid, .id_ready, .id_op, .id_rd, .id_wen,
        .id_src1, .id_src2, .id_imm, .id_pc
    );

    reg_file u_rf (
        .clk,
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wen    (wb_en),
        .waddr  (wb_rd),
        .wdata  (wb_data)
    );

    execute_stage u_execute (
        .clk, .rst_n,
        .id_valid, .id_ready, .id_op, .id_rd, .id_wen,
        .id_src1, .id_src2, .id_imm, .id_pc,
        .ex_valid, .ex_ready, .ex_op, .ex_rd, .ex_wen,
        .ex_result, .ex_store_data, .ex_pc
    );

    mem_stage u_mem (
        .clk, .rst_n,
        .ex_valid, .ex_ready, .ex_op, .ex_rd, .ex_wen,
        .ex_result, .ex_store_data, .ex_pc,
        .dm_req_valid, .dm_req_ready, .dm_req_write, .dm_req_addr, .dm_req_wdata,
        .dm_rsp_valid, .dm_rsp_data,
        .wb_en, .wb_rd, .wb_data,
        .retire_valid, .retire_pc, .retire_wen, .retire_rd, .retire_data,
        .halted
    );

    mem_arbiter u_arb (
        .clk, .rst_n,
        .if_req_valid, .if_req_ready, .if_req_addr, .if_rsp_valid, .if_rsp_data,
        .dm_req_valid, .dm_req_ready, .dm_req_write, .dm_req_addr, .dm_req_wdata,
        .dm_rsp_valid, .dm_rsp_data,
        .mem_req_valid, .mem_req_ready, .mem_req_write, .mem_req_addr, .mem_req_wdata,
        .mem_rsp_valid, .mem_rsp_data
    );

endmodule

// ==== bench/core_properties.sv ====
module core_properties import core_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  mem_req_valid,
    input logic  mem_req_ready,
    input word_t mem_req_addr,
    input logic  retire_valid,
    input logic  halted
);

    timeunit 1ns;
    timeprecision 100ps;

    // a stalled request keeps its address until the memory takes it
    property req_held_until_ready;
        @(posedge clk) disable iff (!rst_n)
            mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr);
    endproperty

    property no_retire_in_reset;
        @(posedge clk) !rst_n |=> !retire_valid;
    endproperty

    // nothing moves once halt has retired
    property halted_sticky;
        @(posedge clk) disable iff (!rst_n)
            halted |=> halted && !retire_valid && !mem_req_valid;
    endproperty

    a_req_held: assert property (req_held_until_ready)
        else $error("memory request dropped or changed address before ready");
    a_reset_quiet: assert property (no_retire_in_reset)
        else $error("retire_valid high during reset");
    a_halted: assert property (halted_sticky)
        else $error("halted fell, or a retire or bus request followed it");

endmodule

bind core_top core_properties u_props (
    .clk, .rst_n, .mem_req_valid, .mem_req_ready, .mem_req_addr, .retire_valid, .halted
);

// ==== bench/tb_core.sv ====
module tb_core import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam word_t RESET_PC   = 32'h0000_0000;
    localparam int    MAX_CYCLES = 4000;  // 40 instructions at 100 cycles worst case

    typedef struct packed {
        word_t    pc;
        logic     wen;
        reg_idx_t rd;
        word_t    data;
    } retire_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    logic     clk;
    logic     rst_n;
    logic     mem_req_valid;
    logic     mem_req_ready;
    logic     mem_req_write;
    word_t    mem_req_addr;
    word_t    mem_req_wdata;
    logic     mem_rsp_valid;
    word_t    mem_rsp_data;
    logic     retire_valid;
    word_t    retire_pc;
    logic     retire_wen;
    reg_idx_t retire_rd;
    word_t    retire_data;
    logic     halted;

    word_t       mem [256];
    word_t       init_mem [256];
    word_t       rsp_data_q [$];   // read data waiting to be returned
    int          rsp_due_q [$];    // cycle from which each response may go out
    retire_t     exp_retire [$];
    store_t      exp_store [$];
    logic [15:0] lfsr_state = 16'd39;
    int          cycle = 0;
    logic        after_halt = 1'b0;

    core_top #(.RESET_PC(RESET_PC)) u_dut (
        .clk, .rst_n,
        .mem_req_valid, .mem_req_ready, .mem_req_write, .mem_req_addr, .mem_req_wdata,
        .mem_rsp_valid, .mem_rsp_data,
        .retire_valid, .retire_pc, .retire_wen, .retire_rd, .retire_data, .halted
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [3:0] draw_bits(input int n);
        logic [3:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[2:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic word_t enc_r(opcode_e op, int rd, int rs1, int rs2);
        return {op, 5'(rd), 5'(rs1), 5'(rs2), 11'd0};
    endfunction

    function automatic word_t enc_i(opcode_e op, int rd, int rs1, int imm);
        return {op, 5'(rd), 5'(rs1), 16'(imm)};
    endfunction

    // rs2 overlaps the upper immediate bits but not the word index
    function automatic word_t enc_s(int rs1, int rs2, int off);
        return {op_sw, 5'd0, 5'(rs1), 5'(rs2), 11'(off)};
    endfunction

    function automatic void load_image();
        for (int i = 0; i < 256; i++) begin
            init_mem[i] = {16'hc0de, 8'(i), 8'(~i)};
        end
        init_mem[64] = 32'h8000_0001;
        init_mem[65] = 32'h0000_00ff;
        init_mem[0]  = enc_i(op_lui, 1, 0, 16'h8000);
        init_mem[1]  = enc_i(op_addi, 1, 1, 5);     // depends on previous
        init_mem[2]  = enc_i(op_addi, 2, 0, -3);
        init_mem[3]  = enc_i(op_addi, 3, 0, 7);
        init_mem[4]  = enc_r(op_add, 4, 1, 3);
        init_mem[5]  = enc_r(op_sub, 5, 3, 2);
        init_mem[6]  = enc_r(op_and, 6, 1, 2);
        init_mem[7]  = enc_r(op_or, 7, 1, 3);
        init_mem[8]  = enc_r(op_xor, 8, 2, 3);
        init_mem[9]  = enc_r(op_slt, 9, 2, 3);      // -3 < 7 signed
        init_mem[10] = enc_r(op_sltu, 10, 2, 3);
        init_mem[11] = enc_r(op_slt, 11, 3, 1);
        init_mem[12] = enc_r(op_sltu, 12, 3, 1);
        init_mem[13] = enc_r(op_sll, 13, 3, 3);
        init_mem[14] = enc_r(op_srl, 14, 1, 3);
        init_mem[15] = enc_r(op_sra, 15, 1, 3);
        init_mem[16] = enc_i(op_addi, 16, 0, 36);   // only low 5 bits count
        init_mem[17] = enc_r(op_sra, 17, 2, 16);
        init_mem[18] = enc_r(op_sll, 18, 1, 16);
        init_mem[19] = enc_i(op_addi, 20, 0, 16'h0100);
        init_mem[20] = enc_i(op_lw, 21, 20, 0);
        init_mem[21] = enc_i(op_lw, 22, 20, 4);
        init_mem[22] = enc_r(op_add, 23, 21, 22);   // waits on both loads
        init_mem[23] = enc_s(20, 23, 8);
        init_mem[24] = enc_i(op_lw, 24, 20, 8);     // reads back the store
        init_mem[25] = enc_s(20, 3, 12);
        init_mem[26] = enc_i(op_lw, 25, 20, 12);
        init_mem[27] = enc_r(op_add, 0, 1, 3);      // r0 writes are dropped
        init_mem[28] = enc_i(op_addi, 0, 0, 99);
        init_mem[29] = enc_r(op_add, 26, 0, 3);
        init_mem[30] = enc_i(op_lw, 0, 20, 0);
        init_mem[31] = enc_r(op_or, 27, 0, 0);
        init_mem[32] = enc_i(op_addi, 28, 26, 1);
        init_mem[33] = enc_i(op_addi, 28, 28, 1);
        init_mem[34] = enc_i(op_addi, 28, 28, 1);
        init_mem[35] = enc_r(op_sub, 29, 28, 26);
        init_mem[36] = enc_s(20, 29, 16);
        init_mem[37] = enc_r(op_xor, 30, 29, 2);
        init_mem[38] = enc_s(20, 30, 20);
        init_mem[39] = {op_halt, 26'd0};
    endfunction

    // sequential interpretation of the program image
    function automatic void run_reference();
        word_t      regs [32];
        word_t      img [256];
        word_t      pc, iw, a, b, imm, res, addr;
        logic [5:0] op;
        logic [4:0] rd;
        logic       wr;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        img = init_mem;
        pc  = RESET_PC;
        for (int n = 0; n < 256; n++) begin
            iw   = img[pc[9:2]];
            op   = iw[31:26];
            rd   = iw[25:21];
            a    = regs[iw[20:16]];
            b    = regs[iw[15:11]];
            imm  = {{16{iw[15]}}, iw[15:0]};
            addr = a + imm;
            res  = '0;
            wr   = 1'b1;
            case (op)
                op_add:  res = a + b;
                op_sub:  res = a - b;
                op_and:  res = a & b;
                op_or:   res = a | b;
                op_xor:  res = a ^ b;
                op_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                op_sltu: res = (a < b) ? 32'd1 : 32'd0;
                op_sll:  res = a << b[4:0];
                op_srl:  res = a >> b[4:0];
                op_sra:  res = $signed(a) >>> b[4:0];
                op_addi: res = addr;
                op_lui:  res = {iw[15:0], 16'h0000};
                op_lw:   res = img[addr[9:2]];
                op_sw: begin
                    img[addr[9:2]] = b;
                    exp_store.push_back({addr, b});
                    wr = 1'b0;
                end
                default: wr = 1'b0;  // halt and unknown opcodes
            endcase
            if (rd == 5'd0) wr = 1'b0;
            if (wr) regs[rd] = res;
            exp_retire.push_back({pc, wr, rd, res});
            if (op == op_halt) break;
            pc = pc + 32'd4;
        end
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_retire();
        retire_t want;
        assert (!after_halt) else report_error("an instruction retired after halt");
        assert (exp_retire.size() > 0) else report_error("more retirements than instructions");
        want = exp_retire.pop_front();
        assert (retire_pc == want.pc)
            else report_mismatch($sformatf("retire pc %h, expected %h", retire_pc, want.pc));
        assert (retire_wen == want.wen)
            else report_mismatch($sformatf("pc %h wen %b, expected %b",
                                           want.pc, retire_wen, want.wen));
        assert (retire_rd == want.rd)
            else report_mismatch($sformatf("pc %h rd %0d, expected %0d",
                                           want.pc, retire_rd, want.rd));
        if (want.wen) begin
            assert (retire_data == want.data)
                else report_mismatch($sformatf("pc %h data %h, expected %h",
                                               want.pc, retire_data, want.data));
        end
        if (exp_retire.size() == 0) begin
            assert (halted) else report_mismatch("halted low when halt retired");
            after_halt = 1'b1;
        end else begin
            assert (!halted) else report_mismatch($sformatf("halted early at pc %h", want.pc));
        end
    endtask

    task automatic check_store();
        store_t want;
        assert (exp_store.size() > 0) else report_error("a store appeared that the program lacks");
        want = exp_store.pop_front();
        assert (mem_req_addr == want.addr)
            else report_mismatch($sformatf("store addr %h, expected %h", mem_req_addr, want.addr));
        assert (mem_req_wdata == want.data)
            else report_mismatch($sformatf("store data %h, expected %h",
                                           mem_req_wdata, want.data));
    endtask

    // memory model samples at the edge and drives 1 ns later
    always @(posedge clk) begin
        cycle++;
        if (rst_n && mem_req_valid && mem_req_ready) begin
            if (mem_req_write) begin
                mem[mem_req_addr[9:2]] = mem_req_wdata;
            end else begin
                rsp_data_q.push_back(mem[mem_req_addr[9:2]]);
                rsp_due_q.push_back(cycle + int'(draw_bits(2)));  // 1 to 4 cycles
            end
        end
        #1;
        mem_req_ready = (draw_bits(2) != 4'd0);  // ready about 3 cycles in 4
        if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
            mem_rsp_valid = 1'b1;
            mem_rsp_data  = rsp_data_q.pop_front();
            void'(rsp_due_q.pop_front());
        end else begin
            mem_rsp_valid = 1'b0;
            mem_rsp_data  = '0;
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (retire_valid) check_retire();
            if (mem_req_valid && mem_req_ready && mem_req_write) check_store();
            assert (!(after_halt && mem_req_valid))
                else report_error("bus request issued after halt");
        end
    end

    initial begin
        rst_n         = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        load_image();
        mem = init_mem;
        run_reference();
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        while (!after_halt && cycle < MAX_CYCLES) @(negedge clk);
        if (!after_halt) begin
            $display("timeout: core did not halt within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $fatal(1, "run aborted");
        end else begin
            repeat (20) @(negedge clk);  // watch for stray retires or requests
            if (exp_retire.size() == 0 && exp_store.size() == 0 && halted) begin
                $display("Test passed");
                $finish;
            end else begin
                $display("run ended with %0d stores still expected", exp_store.size());
                $display("Test failed");
                $fatal(1, "run incomplete");
            end
        end
    end

endmodule

// ==== build.f ====
source/core_pkg.sv
source/alu.sv
source/reg_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_stage.sv
source/mem_arbiter.sv
source/core_top.sv
bench/core_properties.sv
bench/tb_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_core
RTL_TOP   := core_top
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
